// ==== flist.f ====
logic/pipe_pkg.sv
logic/regfile.sv
logic/exe_stage.sv
logic/mult_pipe.sv
logic/mem_stage.sv
logic/bypass_ctrl.sv
logic/pipe_top.sv
tests/pipe_chk.sv
tests/pipe_tb.sv

// ==== logic/bypass_ctrl.sv ====
// bypass_ctrl: newest-producer operand forwarding and issue stall
`timescale 1ns/100ps
module bypass_ctrl (
    input  pipe_pkg::reg_addr_t                             read_addr_a_i,
    input  pipe_pkg::reg_addr_t                             read_addr_b_i,
    input  pipe_pkg::word_t                                 exe_data_i,
    input  pipe_pkg::reg_addr_t                             exe_addr_i,
    input  logic                                            exe_wr_en_i,
    input  pipe_pkg::op_kind_t                              exe_kind_i,
    input  logic                [pipe_pkg::MULT_STAGES-1:0] m_wr_en_i,
    input  pipe_pkg::reg_addr_t [pipe_pkg::MULT_STAGES-1:0] m_addr_i,
    input  pipe_pkg::word_t                                 mult5_data_i,
    input  pipe_pkg::word_t                                 cache_data_i,
    input  pipe_pkg::reg_addr_t                             cache_addr_i,
    input  logic                                            cache_wr_en_i,
    input  pipe_pkg::word_t                                 write_data_i,
    input  pipe_pkg::reg_addr_t                             write_addr_i,
    input  logic                                            write_en_i,
    output logic                                            bypass_a_en_o,
    output logic                                            bypass_b_en_o,
    output pipe_pkg::word_t                                 bypass_data_a_o,
    output pipe_pkg::word_t                                 bypass_data_b_o,
    output logic                                            stall_core_o
);
    import pipe_pkg::*;

    logic stall_a;
    logic stall_b;

    // Producers are searched from youngest to oldest: exe, C/M1, W/M2, M3, M4, M5.
    // The first hit decides, so an older write to the same register is never used.
    function automatic void resolve(
        input  reg_addr_t rd_addr,
        output logic      fwd,
        output word_t     data,
        output logic      stall
    );
        logic found;
        fwd   = 1'b0;
        data  = '0;
        stall = 1'b0;
        found = 1'b0;
        if (rd_addr != '0) begin
            if (exe_wr_en_i && (exe_addr_i == rd_addr)) begin
                found = 1'b1;
                if (exe_kind_i == OP_ALU) begin
                    fwd  = 1'b1;
                    data = exe_data_i;
                end else begin
                    stall = 1'b1; // load or mult not done yet
                end
            end else if (cache_wr_en_i && (cache_addr_i == rd_addr)) begin
                found = 1'b1;
                fwd   = 1'b1;
                data  = cache_data_i;
            end else if (m_wr_en_i[0] && (m_addr_i[0] == rd_addr)) begin
                found = 1'b1;
                stall = 1'b1;
            end else if (write_en_i && (write_addr_i == rd_addr)) begin
                found = 1'b1;
                fwd   = 1'b1;
                data  = write_data_i;
            end
            for (int s = 1; s < MULT_STAGES; s++) begin
                if (!found && m_wr_en_i[s] && (m_addr_i[s] == rd_addr)) begin
                    found = 1'b1;
                    if (s == MULT_STAGES - 1) begin
                        fwd  = 1'b1; // product ready in M5
                        data = mult5_data_i;
                    end else begin
                        stall = 1'b1;
                    end
                end
            end
        end
    endfunction

    always_comb begin
        resolve(read_addr_a_i, bypass_a_en_o, bypass_data_a_o, stall_a);
        resolve(read_addr_b_i, bypass_b_en_o, bypass_data_b_o, stall_b);
    end

    assign stall_core_o = stall_a | stall_b; // independent of issue valid

endmodule

// ==== logic/exe_stage.sv ====
// exe_stage: operand select, issue register and ALU / address adder
`timescale 1ns/100ps
module exe_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  pipe_pkg::op_kind_t  issue_kind_i,
    input  pipe_pkg::reg_addr_t issue_rd_i,
    input  pipe_pkg::word_t     issue_imm_i,
    input  logic                stall_i,
    input  pipe_pkg::word_t     rf_data_a_i,
    input  pipe_pkg::word_t     rf_data_b_i,
    input  logic                bypass_a_en_i,
    input  logic                bypass_b_en_i,
    input  pipe_pkg::word_t     bypass_data_a_i,
    input  pipe_pkg::word_t     bypass_data_b_i,
    output logic                exe_wr_en_o,
    output pipe_pkg::reg_addr_t exe_addr_o,
    output pipe_pkg::op_kind_t  exe_kind_o,
    output pipe_pkg::word_t     exe_result_o,
    output pipe_pkg::word_t     exe_store_data_o,
    output pipe_pkg::word_t     exe_op_a_o,
    output pipe_pkg::word_t     exe_op_b_o
);
    import pipe_pkg::*;

    logic  accept;
    word_t op_a_sel;
    word_t op_b_sel;
    word_t op_a_q;
    word_t op_b_q;
    word_t imm_q;

    assign accept   = issue_valid_i && !stall_i;
    assign op_a_sel = bypass_a_en_i ? bypass_data_a_i : rf_data_a_i;
    assign op_b_sel = bypass_b_en_i ? bypass_data_b_i : rf_data_b_i;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            exe_wr_en_o <= 1'b0;
            exe_kind_o  <= OP_ALU;
            exe_addr_o  <= '0;
        end else if (accept) begin
            exe_wr_en_o <= (issue_kind_i != OP_STORE) && (issue_rd_i != '0);
            exe_kind_o  <= issue_kind_i;
            exe_addr_o  <= issue_rd_i;
        end else begin
            exe_wr_en_o <= 1'b0; // bubble is a non-writing ALU op
            exe_kind_o  <= OP_ALU;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_a_q <= op_a_sel;
            op_b_q <= op_b_sel;
            imm_q  <= issue_imm_i;
        end
    end

    // loads and stores address with a + imm only
    assign exe_result_o     = op_a_q + imm_q + ((exe_kind_o == OP_ALU) ? op_b_q : '0);
    assign exe_store_data_o = op_b_q;
    assign exe_op_a_o       = op_a_q;
    assign exe_op_b_o       = op_b_q;

endmodule

// ==== logic/mem_stage.sv ====
// mem_stage: cache stage with data memory, then the write stage register
`timescale 1ns/100ps
module mem_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::op_kind_t  exe_kind_i,
    input  logic                exe_wr_en_i,
    input  pipe_pkg::reg_addr_t exe_addr_i,
    input  pipe_pkg::word_t     exe_result_i,
    input  pipe_pkg::word_t     exe_store_data_i,
    output logic                c_wr_en_o,
    output pipe_pkg::reg_addr_t c_addr_o,
    output pipe_pkg::word_t     c_data_o,
    output logic                w_wr_en_o,
    output pipe_pkg::reg_addr_t w_addr_o,
    output pipe_pkg::word_t     w_data_o
);
    import pipe_pkg::*;

    localparam int IDX_W = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

    op_kind_t         c_kind_q;
    word_t            c_result_q;     // alu result or memory address
    word_t            c_store_data_q;
    logic [IDX_W-1:0] c_idx;
    word_t            dmem [DMEM_WORDS];

    assign c_idx = IDX_W'((c_result_q >> 2) % DMEM_WORDS); // word address wraps

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            c_wr_en_o <= 1'b0;
            c_kind_q  <= OP_ALU;
            c_addr_o  <= '0;
        end else begin
            c_wr_en_o <= exe_wr_en_i && (exe_kind_i != OP_MULT); // mults go to M1 instead
            c_kind_q  <= (exe_kind_i == OP_MULT) ? OP_ALU : exe_kind_i;
            c_addr_o  <= exe_addr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        c_result_q     <= exe_result_i;
        c_store_data_q <= exe_store_data_i;
    end

    // memory starts out cleared
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < DMEM_WORDS; i++) dmem[i] <= '0;
        end else if (c_kind_q == OP_STORE) begin
            dmem[c_idx] <= c_store_data_q; // written at the edge leaving C
        end
    end

    assign c_data_o = (c_kind_q == OP_LOAD) ? dmem[c_idx] : c_result_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            w_wr_en_o <= 1'b0;
            w_addr_o  <= '0;
        end else begin
            w_wr_en_o <= c_wr_en_o;
            w_addr_o  <= c_addr_o;
        end
    end

    always_ff @(posedge clk_i) begin
        w_data_o <= c_data_o;
    end

endmodule

// ==== logic/mult_pipe.sv ====
// mult_pipe: five-stage 32x32 low-word multiplier with destination tracking
`timescale 1ns/100ps
module mult_pipe (
    input  logic                                               clk_i,
    input  logic                                               rst_n_i,
    input  pipe_pkg::op_kind_t                                 exe_kind_i,
    input  logic                                               exe_wr_en_i,
    input  pipe_pkg::reg_addr_t                                exe_addr_i,
    input  pipe_pkg::word_t                                    exe_op_a_i,
    input  pipe_pkg::word_t                                    exe_op_b_i,
    output logic                [pipe_pkg::MULT_STAGES-1:0]    m_wr_en_o,
    output pipe_pkg::reg_addr_t [pipe_pkg::MULT_STAGES-1:0]    m_addr_o,
    output pipe_pkg::word_t                                    m5_data_o
);
    import pipe_pkg::*;

    word_t        pp_lo_q;    // a_lo * b_lo
    logic [15:0]  pp_cross_q; // low half of the cross terms
    word_t        prod_q [MULT_STAGES-1]; // M2..M5 product
    word_t        cross_full;

    assign cross_full = exe_op_a_i[31:16] * exe_op_b_i[15:0]
                      + exe_op_a_i[15:0]  * exe_op_b_i[31:16];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_wr_en_o <= '0;
            m_addr_o  <= '0;
        end else begin
            m_wr_en_o[0] <= exe_wr_en_i && (exe_kind_i == OP_MULT);
            m_addr_o[0]  <= exe_addr_i;
            for (int s = 1; s < MULT_STAGES; s++) begin
                m_wr_en_o[s] <= m_wr_en_o[s-1]; // always advances
                m_addr_o[s]  <= m_addr_o[s-1];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        pp_lo_q    <= exe_op_a_i[15:0] * exe_op_b_i[15:0];
        pp_cross_q <= cross_full[15:0];
        prod_q[0]  <= pp_lo_q + {pp_cross_q, 16'h0000}; // M2 sum
        for (int s = 1; s < MULT_STAGES - 1; s++) begin
            prod_q[s] <= prod_q[s-1];
        end
    end

    assign m5_data_o = prod_q[MULT_STAGES-2];

endmodule

// ==== logic/pipe_pkg.sv ====
// pipe_pkg: shared widths, operation kind codes and pipeline constants
package pipe_pkg;

    typedef logic [31:0] word_t;     // data word
    typedef logic [4:0]  reg_addr_t; // register index
    typedef logic [1:0]  op_kind_t;  // operation kind

    // operation kinds
    localparam op_kind_t OP_ALU   = 2'd0; // a + b + imm
    localparam op_kind_t OP_LOAD  = 2'd1; // rd <= mem[a + imm]
    localparam op_kind_t OP_STORE = 2'd2; // mem[a + imm] <= b
    localparam op_kind_t OP_MULT  = 2'd3; // low word of a * b

    // multiplier depth, M1 to M5
    localparam int MULT_STAGES = 5;

    // architectural register count
    localparam int REG_COUNT = 32;

endpackage

// ==== logic/pipe_top.sv ====
// pipe_top: forwarding pipeline with exe, cache, write and multiplier stages
`timescale 1ns/100ps
module pipe_top #(
    parameter int DMEM_WORDS = 64
) (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  logic                issue_valid_i,
    input  pipe_pkg::op_kind_t  issue_kind_i,
    input  pipe_pkg::reg_addr_t issue_rd_i,
    input  pipe_pkg::reg_addr_t issue_rs_a_i,
    input  pipe_pkg::reg_addr_t issue_rs_b_i,
    input  pipe_pkg::word_t     issue_imm_i,
    output logic                issue_ready_o,
    output logic                alu_wr_en_o,
    output pipe_pkg::reg_addr_t alu_wr_addr_o,
    output pipe_pkg::word_t     alu_wr_data_o,
    output logic                mult_wr_en_o,
    output pipe_pkg::reg_addr_t mult_wr_addr_o,
    output pipe_pkg::word_t     mult_wr_data_o
);
    import pipe_pkg::*;

    word_t                             rd_data_a, rd_data_b;
    logic                              bypass_a_en, bypass_b_en, stall_core;
    word_t                             bypass_data_a, bypass_data_b;
    logic                              exe_wr_en;
    reg_addr_t                         exe_addr;
    op_kind_t                          exe_kind;
    word_t                             exe_result, exe_store_data, exe_op_a, exe_op_b;
    logic      [MULT_STAGES-1:0]       m_wr_en;
    reg_addr_t [MULT_STAGES-1:0]       m_addr;
    word_t                             m5_data;
    logic                              c_wr_en;
    reg_addr_t                         c_addr;
    word_t                             c_data;

    assign issue_ready_o  = ~stall_core;
    assign mult_wr_en_o   = m_wr_en[MULT_STAGES-1]; // M5 tap
    assign mult_wr_addr_o = m_addr[MULT_STAGES-1];
    assign mult_wr_data_o = m5_data;

    regfile u_regfile (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .rd_addr_a_i(issue_rs_a_i), .rd_addr_b_i(issue_rs_b_i),
        .alu_wr_en_i(alu_wr_en_o), .alu_wr_addr_i(alu_wr_addr_o), .alu_wr_data_i(alu_wr_data_o),
        .mult_wr_en_i(mult_wr_en_o), .mult_wr_addr_i(mult_wr_addr_o),
        .mult_wr_data_i(mult_wr_data_o),
        .rd_data_a_o(rd_data_a), .rd_data_b_o(rd_data_b)
    );

    exe_stage u_exe (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i), .issue_kind_i(issue_kind_i),
        .issue_rd_i(issue_rd_i), .issue_imm_i(issue_imm_i), .stall_i(stall_core),
        .rf_data_a_i(rd_data_a), .rf_data_b_i(rd_data_b),
        .bypass_a_en_i(bypass_a_en), .bypass_b_en_i(bypass_b_en),
        .bypass_data_a_i(bypass_data_a), .bypass_data_b_i(bypass_data_b),
        .exe_wr_en_o(exe_wr_en), .exe_addr_o(exe_addr), .exe_kind_o(exe_kind),
        .exe_result_o(exe_result), .exe_store_data_o(exe_store_data),
        .exe_op_a_o(exe_op_a), .exe_op_b_o(exe_op_b)
    );

    mult_pipe u_mult (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .exe_kind_i(exe_kind), .exe_wr_en_i(exe_wr_en), .exe_addr_i(exe_addr),
        .exe_op_a_i(exe_op_a), .exe_op_b_i(exe_op_b),
        .m_wr_en_o(m_wr_en), .m_addr_o(m_addr), .m5_data_o(m5_data)
    );

    mem_stage #(.DMEM_WORDS(DMEM_WORDS)) u_mem (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .exe_kind_i(exe_kind), .exe_wr_en_i(exe_wr_en), .exe_addr_i(exe_addr),
        .exe_result_i(exe_result), .exe_store_data_i(exe_store_data),
        .c_wr_en_o(c_wr_en), .c_addr_o(c_addr), .c_data_o(c_data),
        .w_wr_en_o(alu_wr_en_o), .w_addr_o(alu_wr_addr_o), .w_data_o(alu_wr_data_o)
    );

    bypass_ctrl u_bypass (
        .read_addr_a_i(issue_rs_a_i), .read_addr_b_i(issue_rs_b_i),
        .exe_data_i(exe_result), .exe_addr_i(exe_addr),
        .exe_wr_en_i(exe_wr_en), .exe_kind_i(exe_kind),
        .m_wr_en_i(m_wr_en), .m_addr_i(m_addr), .mult5_data_i(m5_data),
        .cache_data_i(c_data), .cache_addr_i(c_addr), .cache_wr_en_i(c_wr_en),
        .write_data_i(alu_wr_data_o), .write_addr_i(alu_wr_addr_o),
        .write_en_i(alu_wr_en_o),
        .bypass_a_en_o(bypass_a_en), .bypass_b_en_o(bypass_b_en),
        .bypass_data_a_o(bypass_data_a), .bypass_data_b_o(bypass_data_b),
        .stall_core_o(stall_core)
    );

endmodule

// ==== logic/regfile.sv ====
// regfile: 32-entry register file, two async read ports, two prioritized write ports
`timescale 1ns/100ps
module regfile (
    input  logic                clk_i,
    input  logic                rst_n_i,
    input  pipe_pkg::reg_addr_t rd_addr_a_i,
    input  pipe_pkg::reg_addr_t rd_addr_b_i,
    input  logic                alu_wr_en_i,
    input  pipe_pkg::reg_addr_t alu_wr_addr_i,
    input  pipe_pkg::word_t     alu_wr_data_i,
    input  logic                mult_wr_en_i,
    input  pipe_pkg::reg_addr_t mult_wr_addr_i,
    input  pipe_pkg::word_t     mult_wr_data_i,
    output pipe_pkg::word_t     rd_data_a_o,
    output pipe_pkg::word_t     rd_data_b_o
);
    import pipe_pkg::*;

    word_t regs [REG_COUNT];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (mult_wr_en_i && (mult_wr_addr_i != '0)) regs[mult_wr_addr_i] <= mult_wr_data_i;
            // alu port last so it wins on the same address
            if (alu_wr_en_i && (alu_wr_addr_i != '0)) regs[alu_wr_addr_i] <= alu_wr_data_i;
        end
    end

    assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs[rd_addr_a_i]; // x0 reads zero
    assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs[rd_addr_b_i];

endmodule

// ==== tests/pipe_chk.sv ====
// pipe_chk: concurrent checks on the write ports and issue ready of the pipeline
`timescale 1ns/100ps
module pipe_chk (
    input logic                clk_i,
    input logic                rst_n_i,
    input logic                ready_i,
    input logic                alu_wr_en_i,
    input pipe_pkg::reg_addr_t alu_wr_addr_i,
    input logic                mult_wr_en_i,
    input pipe_pkg::reg_addr_t mult_wr_addr_i
);

    int fail_count = 0; // failed assertions so far

    alu_no_x0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alu_wr_en_i |-> (alu_wr_addr_i != '0))
        else begin
            fail_count++;
            $error("ALU write port targets x0");
        end

    mult_no_x0: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mult_wr_en_i |-> (mult_wr_addr_i != '0))
        else begin
            fail_count++;
            $error("mult write port targets x0");
        end

    // longest stall is a mult consumer waiting for M5
    ready_low_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(ready_i) |-> ##[1:5] ready_i)
        else begin
            fail_count++;
            $error("issue ready low for more than 5 cycles");
        end

    quiet_after_reset: assert property (@(posedge clk_i)
        $rose(rst_n_i) |-> (!alu_wr_en_i && !mult_wr_en_i))
        else begin
            fail_count++;
            $error("write port active in the first cycle after reset");
        end

endmodule

bind pipe_top pipe_chk u_chk (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .ready_i(issue_ready_o),
    .alu_wr_en_i(alu_wr_en_o),
    .alu_wr_addr_i(alu_wr_addr_o),
    .mult_wr_en_i(mult_wr_en_o),
    .mult_wr_addr_i(mult_wr_addr_o)
);

// ==== tests/pipe_tb.sv ====
// pipe_tb: directed table and random stream against a sequential reference model
`timescale 1ns/100ps
module pipe_tb;
    import pipe_pkg::*;

    localparam int NUM_ROWS    = 19;
    localparam int NUM_RANDOM  = 200;
    localparam int WAIT_LIMIT  = 20; // cycles per wait loop
    localparam int DRIVE_DELAY = 1;

    typedef struct packed {
        op_kind_t  kind;
        reg_addr_t rd;
        reg_addr_t rs_a;
        reg_addr_t rs_b;
        word_t     imm;
        logic [3:0] stalls; // expected stall cycles before acceptance
    } row_t;

    logic      clk_i;
    logic      rst_n_i;
    logic      issue_valid_i;
    op_kind_t  issue_kind_i;
    reg_addr_t issue_rd_i;
    reg_addr_t issue_rs_a_i;
    reg_addr_t issue_rs_b_i;
    word_t     issue_imm_i;
    logic      issue_ready_o;
    logic      alu_wr_en_o;
    reg_addr_t alu_wr_addr_o;
    word_t     alu_wr_data_o;
    logic      mult_wr_en_o;
    reg_addr_t mult_wr_addr_o;
    word_t     mult_wr_data_o;

    int        cyc = 0;         // rising edges so far
    int        dmem_words;
    word_t     regs_model [32];
    word_t     mem_model [];
    int        last_mult_edge [4];
    reg_addr_t alu_exp_addr [$];
    word_t     alu_exp_data [$];
    int        alu_exp_cyc [$];
    reg_addr_t mult_exp_addr [$];
    word_t     mult_exp_data [$];
    int        mult_exp_cyc [$];

    // stalls follow from the forwarding rule, ages counted from exe
    row_t rows [NUM_ROWS] = '{
        '{OP_ALU,   5'd1,  5'd0,  5'd0,  32'h5,   4'd0}, // r1 = 5
        '{OP_ALU,   5'd2,  5'd1,  5'd1,  32'h3,   4'd0}, // exe forward
        '{OP_ALU,   5'd3,  5'd2,  5'd1,  32'h7,   4'd0}, // exe and C
        '{OP_ALU,   5'd4,  5'd3,  5'd2,  32'h1,   4'd0},
        '{OP_ALU,   5'd5,  5'd4,  5'd1,  32'h100, 4'd0},
        '{OP_STORE, 5'd0,  5'd1,  5'd4,  32'h20,  4'd0}, // mem[r1 + 0x20] = r4
        '{OP_LOAD,  5'd6,  5'd1,  5'd0,  32'h20,  4'd0},
        '{OP_ALU,   5'd7,  5'd6,  5'd5,  32'h0,   4'd1}, // load in exe
        '{OP_MULT,  5'd8,  5'd5,  5'd7,  32'h0,   4'd0},
        '{OP_ALU,   5'd9,  5'd8,  5'd1,  32'h0,   4'd5}, // waits for M5
        '{OP_MULT,  5'd10, 5'd2,  5'd3,  32'h0,   4'd0}, // m
        '{OP_ALU,   5'd11, 5'd0,  5'd0,  32'h11,  4'd0},
        '{OP_ALU,   5'd12, 5'd11, 5'd0,  32'h1,   4'd0},
        '{OP_ALU,   5'd10, 5'd1,  5'd2,  32'h55,  4'd0}, // m+3, same write cycle
        '{OP_ALU,   5'd13, 5'd12, 5'd0,  32'h2,   4'd0},
        '{OP_ALU,   5'd15, 5'd13, 5'd0,  32'h1,   4'd0},
        '{OP_ALU,   5'd14, 5'd10, 5'd10, 32'h0,   4'd0}, // W and M5 both match
        '{OP_ALU,   5'd16, 5'd10, 5'd0,  32'h0,   4'd0}, // regfile read-back
        '{OP_ALU,   5'd17, 5'd16, 5'd14, 32'h9,   4'd0}
    };

    pipe_top u_dut (
        .clk_i(clk_i), .rst_n_i(rst_n_i),
        .issue_valid_i(issue_valid_i), .issue_kind_i(issue_kind_i),
        .issue_rd_i(issue_rd_i), .issue_rs_a_i(issue_rs_a_i),
        .issue_rs_b_i(issue_rs_b_i), .issue_imm_i(issue_imm_i),
        .issue_ready_o(issue_ready_o),
        .alu_wr_en_o(alu_wr_en_o), .alu_wr_addr_o(alu_wr_addr_o),
        .alu_wr_data_o(alu_wr_data_o),
        .mult_wr_en_o(mult_wr_en_o), .mult_wr_addr_o(mult_wr_addr_o),
        .mult_wr_data_o(mult_wr_data_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    always @(posedge clk_i) cyc <= cyc + 1;

    task automatic stop_failed();
        $display("Simulation FAILED");
        $fatal(1, "testbench stopped at first error");
    endtask

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR @ %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    // sequential semantics, applied in issue order
    task automatic apply_model(input row_t r, input int acc_edge);
        word_t a;
        word_t b;
        word_t res;
        int    idx;
        a   = regs_model[r.rs_a];
        b   = regs_model[r.rs_b];
        idx = ((a + r.imm) >> 2) % dmem_words; // word address wraps
        res = '0;
        case (r.kind)
            OP_ALU:  res = a + b + r.imm;
            OP_LOAD: res = mem_model[idx];
            OP_MULT: res = a * b;
            default: mem_model[idx] = b;
        endcase
        if ((r.kind != OP_STORE) && (r.rd != '0)) begin
            regs_model[r.rd] = res;
            if (r.kind == OP_MULT) begin
                mult_exp_addr.push_back(r.rd);
                mult_exp_data.push_back(res);
                mult_exp_cyc.push_back(acc_edge + 5); // M5 cycle
            end else begin
                alu_exp_addr.push_back(r.rd);
                alu_exp_data.push_back(res);
                alu_exp_cyc.push_back(acc_edge + 2); // W cycle
            end
        end
    endtask

    // holds the row until ready, returns stall count and accepting edge
    task automatic issue_row(input row_t r, output int stalls, output int acc_edge);
        issue_valid_i = 1'b1;
        issue_kind_i  = r.kind;
        issue_rd_i    = r.rd;
        issue_rs_a_i  = r.rs_a;
        issue_rs_b_i  = r.rs_b;
        issue_imm_i   = r.imm;
        stalls        = 0;
        acc_edge      = 0;
        @(negedge clk_i);
        while (!issue_ready_o && (stalls < WAIT_LIMIT)) begin
            stalls++;
            @(negedge clk_i);
        end
        if (!issue_ready_o) begin
            $display("issue ready stayed low for %0d cycles, instruction never accepted", stalls);
            stop_failed();
        end else begin
            acc_edge = cyc + 1;
            apply_model(r, acc_edge);
            @(posedge clk_i);
            #DRIVE_DELAY;
        end
    endtask

    always @(negedge clk_i) begin : alu_port_check
        if (alu_wr_en_o) begin
            if (alu_exp_addr.size() == 0) begin
                $display("ALU write port fired at %0t with no result pending", $time);
                stop_failed();
            end else begin
                check_val("alu port address", alu_wr_addr_o, alu_exp_addr.pop_front());
                check_val("alu port data", alu_wr_data_o, alu_exp_data.pop_front());
                check_val("alu port cycle", cyc, alu_exp_cyc.pop_front());
            end
        end
    end

    always @(negedge clk_i) begin : mult_port_check
        if (mult_wr_en_o) begin
            if (mult_exp_addr.size() == 0) begin
                $display("mult write port fired at %0t with no result pending", $time);
                stop_failed();
            end else begin
                check_val("mult port address", mult_wr_addr_o, mult_exp_addr.pop_front());
                check_val("mult port data", mult_wr_data_o, mult_exp_data.pop_front());
                check_val("mult port cycle", cyc, mult_exp_cyc.pop_front());
            end
        end
    end

    always @(negedge clk_i) begin : assertion_watch
        if (u_dut.u_chk.fail_count != 0) begin
            $display("a bound assertion on the pipeline failed at %0t", $time);
            stop_failed();
        end
    end

    initial begin : main_seq
        row_t r;
        int   stalls;
        int   acc_edge;
        int   waited;
        void'($urandom(20));
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_kind_i  = OP_ALU;
        issue_rd_i    = '0;
        issue_rs_a_i  = '0;
        issue_rs_b_i  = '0;
        issue_imm_i   = '0;
        dmem_words    = u_dut.DMEM_WORDS;
        mem_model     = new[dmem_words];
        for (int i = 0; i < dmem_words; i++) begin
            mem_model[i] = '0;
        end
        for (int i = 0; i < 32; i++) begin
            regs_model[i] = '0;
        end
        for (int i = 0; i < 4; i++) begin
            last_mult_edge[i] = -100;
        end
        repeat (4) @(posedge clk_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;

        for (int i = 0; i < 3; i++) begin
            @(negedge clk_i);
            check_val("ready after reset", issue_ready_o, 1'b1);
            check_val("alu port idle after reset", alu_wr_en_o, 1'b0);
            check_val("mult port idle after reset", mult_wr_en_o, 1'b0);
        end
        @(posedge clk_i);
        #DRIVE_DELAY;

        for (int i = 0; i < NUM_ROWS; i++) begin
            issue_row(rows[i], stalls, acc_edge);
            check_val($sformatf("stall cycles of row %0d", i), stalls, rows[i].stalls);
        end

        for (int n = 0; n < NUM_RANDOM; n++) begin
            r.kind   = op_kind_t'($urandom_range(3, 0));
            r.rd     = reg_addr_t'($urandom_range(3, 0));
            r.rs_a   = reg_addr_t'($urandom_range(3, 0));
            r.rs_b   = reg_addr_t'($urandom_range(3, 0));
            r.imm    = word_t'($urandom_range(255, 0));
            r.stalls = '0;
            // an older mult to the same rd would land later and overwrite it
            if ((r.kind != OP_MULT) && ((cyc + 1) < (last_mult_edge[r.rd] + 3))) begin
                r.rd = '0;
            end
            issue_row(r, stalls, acc_edge);
            if (r.kind == OP_MULT) begin
                last_mult_edge[r.rd] = acc_edge;
            end
        end

        issue_valid_i = 1'b0;
        waited        = 0;
        while (((alu_exp_addr.size() != 0) || (mult_exp_addr.size() != 0))
               && (waited < WAIT_LIMIT)) begin
            @(negedge clk_i);
            waited++;
        end
        if ((alu_exp_addr.size() != 0) || (mult_exp_addr.size() != 0)) begin
            $display("expected results never appeared on the write ports");
            stop_failed();
        end else if (u_dut.u_chk.fail_count != 0) begin
            $display("a bound assertion on the pipeline failed");
            stop_failed();
        end else begin
            $display("Simulation PASSED");
            $finish;
        end
    end

endmodule
